// File: common/rvseed_defines.svh
`ifndef RVSEED_DEFINES_SVH
`define RVSEED_DEFINES_SVH

// width of one integer register and data word
`define RV_XLEN 64

`define RV_REG_ADDR_WIDTH 5 // x0..x31
`define RV_REG_COUNT 32

`endif

// File: common/rv_arch_pkg.sv
package rv_arch_pkg;

    `include "rvseed_defines.svh"

    typedef logic [`RV_XLEN-1:0] xlen_t;           // one data word
    typedef logic [`RV_REG_ADDR_WIDTH-1:0] reg_addr_t; // register index
    typedef logic [31:0] imm_t;                    // s-type offset, sign-extended on use
    typedef logic [`RV_XLEN/8-1:0] wmask_t;        // one enable per byte

    // how the selected result is shaped before write-back
    typedef enum logic [1:0] {
        ext_pass  = 2'd0, // full word, jalr and friends
        ext_sword = 2'd1, // lw, addw, divw
        ext_zword = 2'd2, // lwu
        ext_shalf = 2'd3  // lh
    } ext_mode_e;

endpackage

// File: common/wb_rec_pkg.sv
package wb_rec_pkg;

    import rv_arch_pkg::*;

    // one retired instruction as handed over by the pipeline
    typedef struct packed {
        logic      wen;
        reg_addr_t rd;
        logic      from_mem;  // take mem_res instead of ex_res
        xlen_t     ex_res;
        xlen_t     mem_res;
        ext_mode_e ext_mode;
        logic      is_store;
        reg_addr_t base_reg;  // rs1 of the store
        imm_t      s_imm;
        wmask_t    wmask;
        logic      ebreak;
    } retire_rec_t;

    // request to the external data memory
    typedef struct packed {
        xlen_t  addr;
        xlen_t  data;
        wmask_t wmask;
    } store_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_store,
        st_ack,
        st_halt
    } wb_state_e;

endpackage

// File: wb_stage/wb_ctrl.sv
`timescale 1ns/10ps

module wb_ctrl
    import wb_rec_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        retire_req,
    input  retire_rec_t retire_rec,
    input  logic        st_done,
    output logic        retire_ack,
    output retire_rec_t cur_rec,
    output logic        rf_we,
    output logic        st_start,
    output logic        halted
);

    wb_state_e state_q;
    wb_state_e state_d;
    logic      take_rec;
    logic      halt_done; // ebreak record already acked

    assign take_rec = (state_q == st_idle) && retire_req;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (retire_req) begin
                    if (retire_rec.ebreak)
                        state_d = st_halt; // ebreak wins over store and write
                    else if (retire_rec.is_store)
                        state_d = st_store;
                    else
                        state_d = st_write;
                end
            end
            st_write: state_d = st_ack;
            st_store: begin
                if (st_done)
                    state_d = st_ack;
            end
            st_ack: begin
                if (!retire_req)
                    state_d = st_idle;
            end
            st_halt: state_d = st_halt; // only reset leaves
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            st_start  <= 1'b0;
            halt_done <= 1'b0;
        end else begin
            state_q  <= state_d;
            st_start <= take_rec && !retire_rec.ebreak && retire_rec.is_store;
            if (state_q == st_halt && !retire_req)
                halt_done <= 1'b1;
        end
    end

    // record payload, held for the whole retire
    always_ff @(posedge clk) begin
        if (take_rec)
            cur_rec <= retire_rec;
    end

    assign rf_we      = (state_q == st_write) && cur_rec.wen;
    assign retire_ack = (state_q == st_ack) || (state_q == st_halt && !halt_done);
    assign halted     = (state_q == st_halt);

    // ack may only rise while the upstream still holds its request
    a_ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_ack && !$past(retire_ack)) |-> $past(retire_req));

    // the write happens exactly one cycle after the record was taken
    a_we_in_write: assert property (@(posedge clk) disable iff (!rst_n)
        rf_we |-> (state_q == st_write) && ($past(state_q) == st_idle));

endmodule

// File: wb_stage/wb_extend.sv
`timescale 1ns/10ps

module wb_extend
    import rv_arch_pkg::*;
    import wb_rec_pkg::*;
(
    input  retire_rec_t cur_rec,
    output xlen_t       wb_data
);

    xlen_t src;

    // loads come back through mem_res, everything else through ex_res
    assign src = cur_rec.from_mem ? cur_rec.mem_res : cur_rec.ex_res;

    always_comb begin
        case (cur_rec.ext_mode)
            ext_sword: wb_data = xlen_t'(signed'(src[31:0]));
            ext_zword: wb_data = xlen_t'(src[31:0]);
            ext_shalf: wb_data = xlen_t'(signed'(src[15:0]));
            default:   wb_data = src; // ext_pass
        endcase
    end

endmodule

// File: wb_stage/reg_file.sv
`timescale 1ns/10ps

`include "rvseed_defines.svh"

module reg_file
    import rv_arch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      we,
    input  reg_addr_t waddr,
    input  xlen_t     wdata,
    input  reg_addr_t base_addr,
    input  reg_addr_t dbg_addr,
    output xlen_t     base_data,
    output xlen_t     dbg_data
);

    xlen_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin // x0 is hardwired
            regs[waddr] <= wdata;
        end
    end

    assign base_data = regs[base_addr]; // store base, rs1
    assign dbg_data  = regs[dbg_addr];

    // a write aimed at x0 must leave it reading zero
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (we && waddr == '0) |=> (regs[0] == '0));

endmodule

// File: wb_stage/store_port.sv
`timescale 1ns/10ps

module store_port
    import rv_arch_pkg::*;
    import wb_rec_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       st_start,
    input  xlen_t      base_data,
    input  imm_t       s_imm,
    input  wmask_t     wmask,
    input  xlen_t      wb_data,
    input  logic       mem_ack,
    output logic       mem_req,
    output store_req_t mem_store,
    output logic       st_done
);

    logic ack_seen; // mem_ack came, waiting for it to drop

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req  <= 1'b0;
            ack_seen <= 1'b0;
            st_done  <= 1'b0;
        end else begin
            st_done <= 1'b0;
            if (st_start) begin
                mem_req <= 1'b1;
            end else if (mem_req && mem_ack) begin
                mem_req  <= 1'b0;
                ack_seen <= 1'b1;
            end else if (ack_seen && !mem_ack) begin
                ack_seen <= 1'b0;
                st_done  <= 1'b1; // handshake fully closed
            end
        end
    end

    // request payload, loaded once per store
    always_ff @(posedge clk) begin
        if (st_start) begin
            mem_store.addr  <= base_data + xlen_t'(signed'(s_imm));
            mem_store.data  <= wb_data;
            mem_store.wmask <= wmask;
        end
    end

    // no withdrawal of a request before the memory answered
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_req) |-> $past(mem_ack));

    a_store_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && $past(mem_req)) |-> $stable(mem_store));

endmodule

// File: hw/wb_top.sv
`timescale 1ns/10ps

module wb_top
    import rv_arch_pkg::*;
    import wb_rec_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        retire_req,
    input  retire_rec_t retire_rec,
    input  logic        mem_ack,
    input  reg_addr_t   dbg_addr,
    output logic        retire_ack,
    output logic        mem_req,
    output store_req_t  mem_store,
    output logic        halted,
    output xlen_t       dbg_data
);

    retire_rec_t cur_rec;
    xlen_t       wb_data;   // extended result, also store data
    xlen_t       base_data;
    logic        rf_we;
    logic        st_start;
    logic        st_done;

    wb_ctrl wb_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .retire_req (retire_req),
        .retire_rec (retire_rec),
        .st_done    (st_done),
        .retire_ack (retire_ack),
        .cur_rec    (cur_rec),
        .rf_we      (rf_we),
        .st_start   (st_start),
        .halted     (halted)
    );

    wb_extend wb_extend_i (
        .cur_rec (cur_rec),
        .wb_data (wb_data)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (rf_we),
        .waddr     (cur_rec.rd),
        .wdata     (wb_data),
        .base_addr (cur_rec.base_reg),
        .dbg_addr  (dbg_addr),
        .base_data (base_data),
        .dbg_data  (dbg_data)
    );

    store_port store_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .st_start  (st_start),
        .base_data (base_data),
        .s_imm     (cur_rec.s_imm),
        .wmask     (cur_rec.wmask),
        .wb_data   (wb_data),
        .mem_ack   (mem_ack),
        .mem_req   (mem_req),
        .mem_store (mem_store),
        .st_done   (st_done)
    );

endmodule

// File: test/tb_wb_top.sv
`timescale 1ns/10ps

`include "rvseed_defines.svh"

module tb_wb_top
    import rv_arch_pkg::*;
    import wb_rec_pkg::*;
();

    localparam int ACK_TIMEOUT = 60; // cycles, covers the slowest memory answer

    logic        clk = 1'b0;
    logic        rst_n;
    logic        retire_req;
    retire_rec_t retire_rec;
    logic        mem_ack;
    reg_addr_t   dbg_addr;
    logic        retire_ack;
    logic        mem_req;
    store_req_t  mem_store;
    logic        halted;
    xlen_t       dbg_data;

    int         seed = 32'hf1525075;
    xlen_t      ref_regs [`RV_REG_COUNT];
    xlen_t      ref_dbg;
    logic       ref_halted;
    store_req_t exp_store;
    logic       pending;   // a record is out and may be acked
    logic       sweep_on;  // debug port walk in progress
    int         err_count;
    int         test_num;
    int         tests_ok;
    int         test_errs;
    int         ack_rises;
    logic       ack_prev;
    int         req_rises;
    logic       req_prev;
    int         ack_wait;
    logic       ack_armed;

    wb_top wb_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .retire_req (retire_req),
        .retire_rec (retire_rec),
        .mem_ack    (mem_ack),
        .dbg_addr   (dbg_addr),
        .retire_ack (retire_ack),
        .mem_req    (mem_req),
        .mem_store  (mem_store),
        .halted     (halted),
        .dbg_data   (dbg_data)
    );

    always #5 clk = ~clk;

    assign ref_dbg = ref_regs[dbg_addr];

    // memory side of the store handshake, random answer delay
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_ack   = 1'b0;
            ack_armed = 1'b0;
        end else if (mem_req && !mem_ack) begin
            if (!ack_armed) begin
                ack_wait  = $unsigned($random(seed)) % 6;
                ack_armed = 1'b1;
            end
            if (ack_wait == 0) begin
                mem_ack   = 1'b1;
                ack_armed = 1'b0;
            end else begin
                ack_wait--;
            end
        end else if (mem_ack && !mem_req) begin
            mem_ack = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (retire_ack && !ack_prev)
            ack_rises++;
        if (mem_req && !req_prev)
            req_rises++;
        ack_prev = retire_ack;
        req_prev = mem_req;
    end

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        err_count++;
    endtask

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !retire_ack && !mem_req && !halted)
        else report_error("outputs not low after reset");
    a_dbg_model: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_ack || sweep_on) |-> dbg_data == ref_dbg)
        else report_error($sformatf("x%0d reads %h, expected %h",
                                    dbg_addr, dbg_data, ref_dbg));
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(retire_ack) |-> $past(retire_req) && $past(pending))
        else report_error("retire_ack rose with no record out");
    a_ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_ack && retire_req) |=> retire_ack)
        else report_error("retire_ack fell while req high");
    a_ack_falls_late: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(retire_ack) |-> !$past(retire_req))
        else report_error("retire_ack fell before req");
    a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(retire_req) |-> !retire_ack)
        else report_error("new record while ack still high");
    a_store_payload: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> mem_store == exp_store)
        else report_error($sformatf("store addr %h data %h mask %h, expected %h %h %h",
                                    mem_store.addr, mem_store.data, mem_store.wmask,
                                    exp_store.addr, exp_store.data, exp_store.wmask));
    a_mem_req_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !$past(mem_ack))
        else report_error("mem_req rose while mem_ack high");
    a_mem_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_req) |-> $past(mem_ack))
        else report_error("mem_req fell before mem_ack");
    a_mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && $past(mem_req)) |-> $stable(mem_store))
        else report_error("mem_store changed during request");
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else report_error("halted dropped without reset");
    a_no_ack_halted: assert property (@(posedge clk) disable iff (!rst_n)
        $past(halted) |-> !$rose(retire_ack))
        else report_error("record acked after halt");

    function automatic xlen_t shape_result(input retire_rec_t rec);
        xlen_t s;
        s = rec.from_mem ? rec.mem_res : rec.ex_res;
        case (rec.ext_mode)
            ext_sword: return {{32{s[31]}}, s[31:0]};
            ext_zword: return {32'h0, s[31:0]};
            ext_shalf: return {{48{s[15]}}, s[15:0]};
            default:   return s;
        endcase
    endfunction

    // reference: ebreak beats store beats write, nothing moves once halted
    function automatic void apply_model(input retire_rec_t rec);
        if (ref_halted) begin
        end else if (rec.ebreak) begin
            ref_halted = 1'b1;
        end else if (rec.is_store) begin
            exp_store.addr  = ref_regs[rec.base_reg] + {{32{rec.s_imm[31]}}, rec.s_imm};
            exp_store.data  = shape_result(rec);
            exp_store.wmask = rec.wmask;
        end else if (rec.wen && rec.rd != 5'd0) begin
            ref_regs[rec.rd] = shape_result(rec);
        end
    endfunction

    function automatic xlen_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic retire_rec_t write_rec(input int rd, input logic from_mem, input xlen_t ex,
                                              input xlen_t mem, input int mode);
        retire_rec_t rec;
        rec          = '0;
        rec.wen      = 1'b1;
        rec.rd       = reg_addr_t'(rd);
        rec.from_mem = from_mem;
        rec.ex_res   = ex;
        rec.mem_res  = mem;
        rec.ext_mode = ext_mode_e'(mode[1:0]);
        return rec;
    endfunction

    task automatic send_rec(input retire_rec_t rec, input int hold, input logic expect_ack);
        int   cycles;
        logic got_ack;
        @(negedge clk);
        retire_rec = rec;
        retire_req = 1'b1;
        pending    = 1'b1;
        dbg_addr   = rec.rd; // written register is checked while ack is high
        apply_model(rec);
        cycles = 0;
        while (!retire_ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        got_ack = retire_ack;
        if (got_ack)
            repeat (hold) @(negedge clk);
        retire_req = 1'b0;
        pending    = 1'b0;
        if (expect_ack && !got_ack) begin
            $display("timeout at %0t: no retire_ack for record to x%0d", $time, rec.rd);
            err_count++;
        end
        assert (expect_ack || !got_ack)
            else report_error($sformatf("record to x%0d acked while halted", rec.rd));
        cycles = 0;
        while (retire_ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (retire_ack) begin
            $display("timeout at %0t: retire_ack stayed high after req fell", $time);
            err_count++;
        end
    endtask

    task automatic sweep_regs();
        sweep_on = 1'b1;
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            @(negedge clk);
            dbg_addr = reg_addr_t'(i);
        end
        @(negedge clk);
        sweep_on = 1'b0;
    endtask

    task automatic start_test();
        test_num++;
        test_errs = err_count;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_errs) begin
            tests_ok++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, err_count - test_errs);
        end
    endtask

    initial begin
        retire_rec_t rec;
        int          sent;
        rst_n      = 1'b0;
        retire_req = 1'b0;
        retire_rec = '0;
        mem_ack    = 1'b0;
        dbg_addr   = '0;
        ref_halted = 1'b0;
        exp_store  = '0;
        pending    = 1'b0;
        sweep_on   = 1'b0;
        ack_prev   = 1'b0;
        req_prev   = 1'b0;
        ack_armed  = 1'b0;
        ack_wait   = 0;
        err_count  = 0;
        test_num   = 0;
        tests_ok   = 0;
        ack_rises  = 0;
        req_rises  = 0;
        for (int i = 0; i < `RV_REG_COUNT; i++)
            ref_regs[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test();
        sweep_regs();
        end_test("reset state");

        start_test();
        for (int m = 0; m < 4; m++)
            for (int fm = 0; fm < 2; fm++)
                for (int k = 0; k < 2; k++)
                    send_rec(write_rec(1 + m * 4 + fm * 2 + k, fm[0],
                             k ? rand_word() & ~64'h8000_8000 : rand_word() | 64'h8000_8000,
                             k ? rand_word() & ~64'h8000_8000 : rand_word() | 64'h8000_8000,
                             m), 0, 1'b1);
        end_test("extension modes");

        start_test();
        send_rec(write_rec(0, 1'b0, 64'hdead_beef_cafe_f00d, 64'h0, 0), 0, 1'b1);
        rec     = write_rec(3, 1'b0, 64'h1111_2222_3333_4444, 64'h0, 0);
        rec.wen = 1'b0; // x3 must keep its old value
        send_rec(rec, 0, 1'b1);
        sweep_regs();
        end_test("x0 and wen clear");

        start_test();
        for (int i = 1; i < `RV_REG_COUNT; i++)
            send_rec(write_rec(i, 1'b0, rand_word(), 64'h0, 0), 0, 1'b1);
        sent = req_rises;
        for (int n = 0; n < 16; n++) begin
            rec          = write_rec(0, 1'($random(seed)), rand_word(), rand_word(),
                                     $unsigned($random(seed)) % 4);
            rec.wen      = 1'b0;
            rec.is_store = 1'b1;
            rec.base_reg = reg_addr_t'($unsigned($random(seed)) % 32);
            rec.s_imm    = imm_t'($random(seed) % 2048);
            rec.wmask    = wmask_t'($random(seed));
            send_rec(rec, $unsigned($random(seed)) % 3, 1'b1);
        end
        assert (req_rises - sent == 16)
            else report_error($sformatf("%0d memory requests for 16 stores", req_rises - sent));
        end_test("stores");

        start_test();
        sent = ack_rises;
        for (int n = 0; n < 6; n++)
            send_rec(write_rec(20 + n, 1'b1, rand_word(), rand_word(),
                               $unsigned($random(seed)) % 4),
                     1 + $unsigned($random(seed)) % 4, 1'b1);
        assert (ack_rises - sent == 6)
            else report_error($sformatf("%0d acks for 6 records", ack_rises - sent));
        end_test("back to back");

        start_test();
        rec        = write_rec(7, 1'b0, 64'h7777_7777_7777_7777, 64'h0, 0);
        rec.ebreak = 1'b1;
        send_rec(rec, 2, 1'b1);
        assert (halted)
            else report_error("halted low after ebreak");
        send_rec(write_rec(5, 1'b0, 64'h5555_aaaa_5555_aaaa, 64'h0, 0), 0, 1'b0);
        sweep_regs();
        end_test("ebreak halt");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_num, tests_ok, test_num - tests_ok, err_count);
        if (err_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // run limit in case a wait escapes its own timeout
    initial begin
        #200000;
        $display("simulation time limit reached before the tests finished");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+common
common/rv_arch_pkg.sv
common/wb_rec_pkg.sv
wb_stage/wb_ctrl.sv
wb_stage/wb_extend.sv
wb_stage/reg_file.sv
wb_stage/store_port.sv
hw/wb_top.sv
test/tb_wb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the write-back testbench with Verilator.
set -o pipefail

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_wb_top \
    --Mdir obj_dir \
    -o tb_wb_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_wb_top 2>&1 | tee "$SIM_LOG"
if [ $? -ne 0 ]; then
    echo "simulation exited with an error status"
    exit 1
fi

if grep -q "^Verification passed$" "$SIM_LOG"; then
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
